// File: src/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int imemAddrWidth = 32;
    localparam int dmemWords = 256;
    localparam int dmemIdxWidth = $clog2(dmemWords);

    // primary opcodes of the supported subset
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // function field values, only meaningful when the opcode is R-type
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [1:0] {
        fwdOri = 2'd0,
        fwdM = 2'd1,
        fwdW = 2'd2
    } fwdSel;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp;

    // all zeros is a bubble that neither writes nor branches
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic aluSrcImm;
        logic zeroExt;
        logic branch;
        logic branchNe;
        aluOp aluOp;
    } ctlT;

    typedef struct packed {
        ctlT ctl;
        logic [dataWidth-1:0] srcA;
        logic [dataWidth-1:0] srcB;
        logic [dataWidth-1:0] imm;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
    } decodeToExecT;

    typedef struct packed {
        ctlT ctl;
        logic [dataWidth-1:0] aluOut;
        logic [dataWidth-1:0] writeData;
        logic [regAddrWidth-1:0] dest;
    } execToMemT;

    typedef struct packed {
        ctlT ctl;
        logic [dataWidth-1:0] aluOut;
        logic [dataWidth-1:0] readData;
        logic [regAddrWidth-1:0] dest;
    } memToWbT;

    // operand mux shared by the decode and execute forwarding paths
    function automatic logic [dataWidth-1:0] pickOperand(
        input fwdSel sel,
        input logic [dataWidth-1:0] ori,
        input logic [dataWidth-1:0] fromM,
        input logic [dataWidth-1:0] fromW
    );
        case (sel)
            fwdM: return fromM;
            fwdW: return fromW;
            default: return ori;
        endcase
    endfunction

endpackage

// File: src/pipeReg.sv
module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // flush wins over stall so a bubble always gets inserted when asked for
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: src/hazardUnit.sv
module hazardUnit (
    input  logic [mipsPkg::regAddrWidth-1:0] rsD,
    input  logic [mipsPkg::regAddrWidth-1:0] rtD,
    input  logic                             branchD,
    input  logic [mipsPkg::regAddrWidth-1:0] rsE,
    input  logic [mipsPkg::regAddrWidth-1:0] rtE,
    input  logic [mipsPkg::regAddrWidth-1:0] destE,
    input  logic                             regWriteE,
    input  logic                             memReadE,
    input  logic [mipsPkg::regAddrWidth-1:0] destM,
    input  logic                             regWriteM,
    input  logic                             memReadM,
    input  logic [mipsPkg::regAddrWidth-1:0] destW,
    input  logic                             regWriteW,
    output logic                             stallF,
    output logic                             stallD,
    output logic                             flushE,
    output mipsPkg::fwdSel                   forwardAD,
    output mipsPkg::fwdSel                   forwardBD,
    output mipsPkg::fwdSel                   forwardAE,
    output mipsPkg::fwdSel                   forwardBE
);
    import mipsPkg::*;

    logic loadUseStall;
    logic branchOnExec;
    logic branchOnLoad;
    logic branchStall;

    // the memory stage holds the younger result, so it is checked first
    function automatic fwdSel pickSource(
        input logic [regAddrWidth-1:0] src,
        input logic [regAddrWidth-1:0] dstM,
        input logic                    wrM,
        input logic [regAddrWidth-1:0] dstW,
        input logic                    wrW
    );
        if (src != '0 && src == dstM && wrM) begin
            return fwdM;
        end else if (src != '0 && src == dstW && wrW) begin
            return fwdW;
        end
        return fwdOri;
    endfunction

    assign forwardAE = pickSource(rsE, destM, regWriteM, destW, regWriteW);
    assign forwardBE = pickSource(rtE, destM, regWriteM, destW, regWriteW);
    assign forwardAD = pickSource(rsD, destM, regWriteM, destW, regWriteW);
    assign forwardBD = pickSource(rtD, destM, regWriteM, destW, regWriteW);

    // a load in execute has no data yet for the instruction behind it
    assign loadUseStall = memReadE && destE != '0 && (rsD == destE || rtD == destE);

    // the branch compares in decode, so it also waits on an ALU result still in execute
    assign branchOnExec = regWriteE && destE != '0 && (rsD == destE || rtD == destE);
    // load data only appears at the end of the memory stage
    assign branchOnLoad = memReadM && destM != '0 && (rsD == destM || rtD == destM);
    assign branchStall = branchD && (branchOnExec || branchOnLoad);

    assign stallF = loadUseStall || branchStall;
    assign stallD = stallF;
    assign flushE = stallF;

endmodule

// File: src/fetchStage.sv
module fetchStage (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              stall,
    input  logic                              branchTaken,
    input  logic [mipsPkg::dataWidth-1:0]     branchTarget,
    output logic [mipsPkg::imemAddrWidth-1:0] pc,
    output logic [mipsPkg::dataWidth-1:0]     pcPlus4
);
    import mipsPkg::*;

    logic [imemAddrWidth-1:0] pcNext;

    assign pcPlus4 = dataWidth'(pc) + dataWidth'(4);

    // a taken branch redirects after the delay slot, which is already being fetched
    assign pcNext = branchTaken ? imemAddrWidth'(branchTarget) : imemAddrWidth'(pcPlus4);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

endmodule

// File: src/decodeStage.sv
module decodeStage (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [mipsPkg::dataWidth-1:0]    instr,
    input  logic [mipsPkg::dataWidth-1:0]    pcPlus4,
    input  logic                             wbEn,
    input  logic [mipsPkg::regAddrWidth-1:0] wbReg,
    input  logic [mipsPkg::dataWidth-1:0]    wbData,
    input  logic [mipsPkg::dataWidth-1:0]    resultM,
    input  mipsPkg::fwdSel                   forwardAD,
    input  mipsPkg::fwdSel                   forwardBD,
    output mipsPkg::decodeToExecT            out,
    output logic                             branchTaken,
    output logic [mipsPkg::dataWidth-1:0]    branchTarget
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [15:0] immField;
    ctlT ctl;
    logic [dataWidth-1:0] regs [2**regAddrWidth];
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] cmpA;
    logic [dataWidth-1:0] cmpB;
    logic [dataWidth-1:0] immSign;
    logic [dataWidth-1:0] immExt;

    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign funct = instr[5:0];
    assign immField = instr[15:0];

    // anything outside the subset decodes as a nop
    always_comb begin
        ctl = '0;
        case (opcode)
            opRtype: begin
                ctl.regWrite = 1'b1;
                case (funct)
                    fnAddu: ctl.aluOp = aluAdd;
                    fnSubu: ctl.aluOp = aluSub;
                    fnAnd: ctl.aluOp = aluAnd;
                    fnOr: ctl.aluOp = aluOr;
                    fnSlt: ctl.aluOp = aluSlt;
                    default: ctl.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                ctl.regWrite = 1'b1;
                ctl.aluSrcImm = 1'b1;
                ctl.aluOp = aluAdd;
            end
            opOri: begin
                ctl.regWrite = 1'b1;
                ctl.aluSrcImm = 1'b1;
                ctl.zeroExt = 1'b1;
                ctl.aluOp = aluOr;
            end
            opLui: begin
                ctl.regWrite = 1'b1;
                ctl.aluSrcImm = 1'b1;
                ctl.aluOp = aluLui;
            end
            opLw: begin
                ctl.regWrite = 1'b1;
                ctl.memRead = 1'b1;
                ctl.aluSrcImm = 1'b1;
                ctl.aluOp = aluAdd;
            end
            opSw: begin
                ctl.memWrite = 1'b1;
                ctl.aluSrcImm = 1'b1;
                ctl.aluOp = aluAdd;
            end
            opBeq: ctl.branch = 1'b1;
            opBne: begin
                ctl.branch = 1'b1;
                ctl.branchNe = 1'b1;
            end
            default: ctl = '0;
        endcase
    end

    // register 0 is never written because the top masks wbEn for it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wbReg] <= wbData;
        end
    end

    // a write in this same cycle is seen by the read
    assign regA = (rs == '0) ? '0 : ((wbEn && wbReg == rs) ? wbData : regs[rs]);
    assign regB = (rt == '0) ? '0 : ((wbEn && wbReg == rt) ? wbData : regs[rt]);

    assign cmpA = pickOperand(forwardAD, regA, resultM, wbData);
    assign cmpB = pickOperand(forwardBD, regB, resultM, wbData);

    assign immSign = {{(dataWidth-16){immField[15]}}, immField};
    assign immExt = ctl.zeroExt ? {{(dataWidth-16){1'b0}}, immField} : immSign;

    assign branchTaken = ctl.branch && ((cmpA == cmpB) ^ ctl.branchNe);
    assign branchTarget = pcPlus4 + {immSign[dataWidth-3:0], 2'b00};

    assign out.ctl = ctl;
    assign out.srcA = regA;
    assign out.srcB = regB;
    assign out.imm = immExt;
    assign out.rs = rs;
    assign out.rt = rt;
    assign out.rd = rd;

endmodule

// File: src/executeStage.sv
module executeStage (
    input  mipsPkg::decodeToExecT         in,
    input  logic [mipsPkg::dataWidth-1:0] resultM,
    input  logic [mipsPkg::dataWidth-1:0] wbData,
    input  mipsPkg::fwdSel                forwardAE,
    input  mipsPkg::fwdSel                forwardBE,
    output mipsPkg::execToMemT            out
);
    import mipsPkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] fwdB;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;

    assign opA = pickOperand(forwardAE, in.srcA, resultM, wbData);
    assign fwdB = pickOperand(forwardBE, in.srcB, resultM, wbData);
    assign opB = in.ctl.aluSrcImm ? in.imm : fwdB;

    always_comb begin
        case (in.ctl.aluOp)
            aluAdd: aluResult = opA + opB;
            aluSub: aluResult = opA - opB;
            aluAnd: aluResult = opA & opB;
            aluOr: aluResult = opA | opB;
            // signed compare, unlike sltu
            aluSlt: aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluLui: aluResult = {opB[15:0], 16'b0};
            default: aluResult = '0;
        endcase
    end

    assign out.ctl = in.ctl;
    assign out.aluOut = aluResult;
    // stores take rt after forwarding, not the immediate
    assign out.writeData = fwdB;
    // every I-type in the subset has aluSrcImm set, and they write rt
    assign out.dest = in.ctl.aluSrcImm ? in.rt : in.rd;

endmodule

// File: src/memoryStage.sv
module memoryStage (
    input  logic                          clk,
    input  logic                          arstN,
    input  mipsPkg::execToMemT            in,
    output mipsPkg::memToWbT              out,
    output logic                          storeEn,
    output logic [mipsPkg::dataWidth-1:0] storeAddr,
    output logic [mipsPkg::dataWidth-1:0] storeData
);
    import mipsPkg::*;

    logic [dataWidth-1:0] ram [dmemWords];
    logic [dmemIdxWidth-1:0] wordIdx;

    // word addressed, the upper address bits simply wrap around the RAM
    assign wordIdx = in.aluOut[2 +: dmemIdxWidth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                ram[i] <= '0;
            end
        end else if (in.ctl.memWrite) begin
            ram[wordIdx] <= in.writeData;
        end
    end

    assign storeEn = in.ctl.memWrite;
    assign storeAddr = in.aluOut;
    assign storeData = in.writeData;

    assign out.ctl = in.ctl;
    assign out.aluOut = in.aluOut;
    assign out.readData = ram[wordIdx];
    assign out.dest = in.dest;

endmodule

// File: src/mipsCore.sv
module mipsCore (
    input  logic                              clk,
    input  logic                              arstN,
    output logic [mipsPkg::imemAddrWidth-1:0] imemAddr,
    input  logic [mipsPkg::dataWidth-1:0]     imemData,
    output logic                              wbEn,
    output logic [mipsPkg::regAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::dataWidth-1:0]     wbData,
    output logic                              storeEn,
    output logic [mipsPkg::dataWidth-1:0]     storeAddr,
    output logic [mipsPkg::dataWidth-1:0]     storeData
);
    import mipsPkg::*;

    logic [dataWidth-1:0] pcPlus4F;
    logic [2*dataWidth-1:0] fdIn;
    logic [2*dataWidth-1:0] fdQ;
    decodeToExecT deIn;
    decodeToExecT deQ;
    execToMemT emIn;
    execToMemT emQ;
    memToWbT mwIn;
    memToWbT mwQ;
    logic branchTaken;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] resultM;
    logic stallF;
    logic stallD;
    logic flushE;
    fwdSel forwardAD;
    fwdSel forwardBD;
    fwdSel forwardAE;
    fwdSel forwardBE;

    fetchStage fetch (
        .clk(clk),
        .arstN(arstN),
        .stall(stallF),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .pc(imemAddr),
        .pcPlus4(pcPlus4F)
    );

    // instruction in the upper half, PC+4 in the lower
    assign fdIn = {imemData, pcPlus4F};

    pipeReg #(.payloadT(logic [2*dataWidth-1:0])) regFD (
        .clk(clk),
        .arstN(arstN),
        .stall(stallD),
        .flush(1'b0),
        .d(fdIn),
        .q(fdQ)
    );

    decodeStage decode (
        .clk(clk),
        .arstN(arstN),
        .instr(fdQ[2*dataWidth-1:dataWidth]),
        .pcPlus4(fdQ[dataWidth-1:0]),
        .wbEn(wbEn),
        .wbReg(wbReg),
        .wbData(wbData),
        .resultM(resultM),
        .forwardAD(forwardAD),
        .forwardBD(forwardBD),
        .out(deIn),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    pipeReg #(.payloadT(decodeToExecT)) regDE (
        .clk(clk),
        .arstN(arstN),
        .stall(1'b0),
        .flush(flushE),
        .d(deIn),
        .q(deQ)
    );

    executeStage execute (
        .in(deQ),
        .resultM(resultM),
        .wbData(wbData),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE),
        .out(emIn)
    );

    pipeReg #(.payloadT(execToMemT)) regEM (
        .clk(clk),
        .arstN(arstN),
        .stall(1'b0),
        .flush(1'b0),
        .d(emIn),
        .q(emQ)
    );

    memoryStage memory (
        .clk(clk),
        .arstN(arstN),
        .in(emQ),
        .out(mwIn),
        .storeEn(storeEn),
        .storeAddr(storeAddr),
        .storeData(storeData)
    );

    pipeReg #(.payloadT(memToWbT)) regMW (
        .clk(clk),
        .arstN(arstN),
        .stall(1'b0),
        .flush(1'b0),
        .d(mwIn),
        .q(mwQ)
    );

    // a load never forwards from the memory stage, the hazard unit stalls first
    assign resultM = emQ.aluOut;

    assign wbEn = mwQ.ctl.regWrite && mwQ.dest != '0;
    assign wbReg = mwQ.dest;
    assign wbData = mwQ.ctl.memRead ? mwQ.readData : mwQ.aluOut;

    hazardUnit hazard (
        .rsD(deIn.rs),
        .rtD(deIn.rt),
        .branchD(deIn.ctl.branch),
        .rsE(deQ.rs),
        .rtE(deQ.rt),
        .destE(emIn.dest),
        .regWriteE(deQ.ctl.regWrite),
        .memReadE(deQ.ctl.memRead),
        .destM(emQ.dest),
        .regWriteM(emQ.ctl.regWrite),
        .memReadM(emQ.ctl.memRead),
        .destW(mwQ.dest),
        .regWriteW(mwQ.ctl.regWrite),
        .stallF(stallF),
        .stallD(stallD),
        .flushE(flushE),
        .forwardAD(forwardAD),
        .forwardBD(forwardBD),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE)
    );

endmodule

// File: bench/mipsCoreTb.sv
module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    logic clk;
    logic arstN;
    logic [imemAddrWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    logic wbEn;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0] wbData;
    logic storeEn;
    logic [dataWidth-1:0] storeAddr;
    logic [dataWidth-1:0] storeData;

    logic [31:0] prog [1024];
    int progLen;
    int endIdx;
    logic [31:0] rngState;
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [dmemWords];
    logic [4:0] expRegQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] expAddrQ [$];
    logic [31:0] expStoreQ [$];
    string testName;
    int testErrors;
    logic running;
    int passCount;
    int failCount;

    mipsCore UUT (
        .clk(clk),
        .arstN(arstN),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wbEn(wbEn),
        .wbReg(wbReg),
        .wbData(wbData),
        .storeEn(storeEn),
        .storeAddr(storeAddr),
        .storeData(storeData)
    );

    // instruction memory answers in the same cycle, anything outside it reads as a nop
    assign imemData = (imemAddr[31:12] == '0) ? prog[imemAddr[11:2]] : 32'h0;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return nextRand() % n;
    endfunction

    function automatic logic [4:0] pickReg(input int unsigned n);
        return 5'(pick(n));
    endfunction

    // word-aligned offset anywhere in the data RAM
    function automatic logic [15:0] pickOffset();
        return 16'(pick(dmemWords) * 4);
    endfunction

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
        return {opRtype, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // random ALU or immediate instruction over registers 0 to n-1
    function automatic logic [31:0] randomAlu(input int unsigned n);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        rs = pickReg(n);
        rt = pickReg(n);
        rd = pickReg(n);
        imm = 16'(nextRand());
        case (pick(8))
            0: return encR(fnAddu, rs, rt, rd);
            1: return encR(fnSubu, rs, rt, rd);
            2: return encR(fnAnd, rs, rt, rd);
            3: return encR(fnOr, rs, rt, rd);
            4: return encR(fnSlt, rs, rt, rd);
            5: return encI(opAddiu, rs, rt, imm);
            6: return encI(opOri, rs, rt, imm);
            default: return encI(opLui, 5'd0, rt, imm);
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: test %s, %s: expected %h, actual %h",
                     testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // executes the program one instruction at a time, delay slots included
    task automatic runModel();
        int pc;
        int npc;
        int target;
        int steps;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0] dest;
        logic writes;
        logic taken;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            modelMem[i] = '0;
        end
        pc = 0;
        npc = 1;
        steps = 0;
        while (pc != endIdx && steps < 4096) begin
            w = prog[pc];
            a = modelRegs[w[25:21]];
            b = modelRegs[w[20:16]];
            sImm = {{16{w[15]}}, w[15:0]};
            addr = a + sImm;
            dest = w[20:16];
            writes = 1'b1;
            taken = 1'b0;
            val = '0;
            case (w[31:26])
                opRtype: begin
                    dest = w[15:11];
                    case (w[5:0])
                        fnAddu: val = a + b;
                        fnSubu: val = a - b;
                        fnAnd: val = a & b;
                        fnOr: val = a | b;
                        fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opAddiu: val = a + sImm;
                opOri: val = a | {16'h0, w[15:0]};
                opLui: val = {w[15:0], 16'h0};
                opLw: val = modelMem[addr[9:2]];
                opSw: begin
                    writes = 1'b0;
                    modelMem[addr[9:2]] = b;
                    expAddrQ.push_back(addr);
                    expStoreQ.push_back(b);
                end
                opBeq: begin
                    writes = 1'b0;
                    taken = (a == b);
                end
                opBne: begin
                    writes = 1'b0;
                    taken = (a != b);
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                modelRegs[dest] = val;
                expRegQ.push_back(dest);
                expDataQ.push_back(val);
            end
            // the target counts from the delay slot, which runs either way
            target = taken ? pc + 1 + int'($signed(w[15:0])) : npc + 1;
            pc = npc;
            npc = target;
            steps++;
        end
    endtask

    always @(negedge clk) begin
        if (arstN && running) begin
            // fetch stays word aligned and never runs past the parking nop
            checkValue("fetch alignment", 32'h0, 32'(imemAddr[1:0]));
            if (imemAddr > 32'((endIdx + 1) * 4)) begin
                $display("test %s: the core fetched from %h beyond the end of the program",
                         testName, imemAddr);
                testErrors++;
            end
            if (wbEn) begin
                if (expRegQ.size() == 0) begin
                    $display("test %s: the core wrote r%0d although no write was left",
                             testName, wbReg);
                    testErrors++;
                end else begin
                    checkValue("write register", 32'(expRegQ.pop_front()), 32'(wbReg));
                    checkValue("write data", expDataQ.pop_front(), wbData);
                end
            end
            if (storeEn) begin
                if (expAddrQ.size() == 0) begin
                    $display("test %s: the core stored to %h although no store was left",
                             testName, storeAddr);
                    testErrors++;
                end else begin
                    checkValue("store address", expAddrQ.pop_front(), storeAddr);
                    checkValue("store data", expStoreQ.pop_front(), storeData);
                end
            end
        end
    end

    task automatic startTest(input string name);
        @(posedge clk);
        arstN <= 1'b0;
        running = 1'b0;
        testName = name;
        testErrors = 0;
        progLen = 0;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = '0;
        end
        expRegQ.delete();
        expDataQ.delete();
        expAddrQ.delete();
        expStoreQ.delete();
    endtask

    task automatic runTest();
        int cyc;
        int idle;
        int left;
        int lastLeft;
        int nWrites;
        int nStores;
        // a self-branch and its nop slot park the core once the program is done
        endIdx = progLen;
        emit(encI(opBeq, 5'd0, 5'd0, 16'hffff));
        emit(32'h0);
        runModel();
        nWrites = expRegQ.size();
        nStores = expAddrQ.size();
        for (cyc = 0; cyc < 8; cyc++) begin
            @(posedge clk);
        end
        arstN <= 1'b1;
        running = 1'b1;
        idle = 0;
        lastLeft = -1;
        left = nWrites + nStores;
        while (left != 0 && idle < 2000) begin
            @(posedge clk);
            left = expRegQ.size() + expAddrQ.size();
            if (left != lastLeft) begin
                idle = 0;
                lastLeft = left;
            end else begin
                idle++;
            end
        end
        if (left != 0) begin
            $display("test %s: the core stopped retiring with %0d events still expected",
                     testName, left);
            testErrors++;
        end
        // a few more cycles so that a stray extra event is still caught
        for (cyc = 0; cyc < 16; cyc++) begin
            @(posedge clk);
        end
        running = 1'b0;
        if (testErrors == 0) begin
            $display("test %s: passed, %0d writes and %0d stores checked",
                     testName, nWrites, nStores);
            passCount++;
        end else begin
            $display("test %s: %0d errors", testName, testErrors);
            failCount++;
        end
    endtask

    task automatic buildAlu();
        for (int i = 0; i < 48; i++) begin
            emit(randomAlu(32));
            for (int j = 0; j < 3; j++) begin
                emit(32'h0);
            end
        end
    endtask

    // four registers and short gaps give dependency distances of one to three
    task automatic buildForward();
        int gap;
        for (int i = 0; i < 80; i++) begin
            emit(randomAlu(4));
            gap = int'(pick(3));
            for (int j = 0; j < gap; j++) begin
                emit(32'h0);
            end
        end
    endtask

    task automatic buildMemory();
        logic [4:0] rv;
        logic [4:0] rl;
        logic [4:0] rc;
        logic [15:0] off;
        logic [15:0] offPrev;
        offPrev = pickOffset();
        for (int i = 0; i < 24; i++) begin
            rv = 5'd1 + pickReg(7);
            rl = 5'd1 + pickReg(7);
            rc = 5'd1 + pickReg(7);
            off = pickOffset();
            emit(encI(opLui, 5'd0, rv, 16'(nextRand())));
            emit(encI(opOri, rv, rv, 16'(nextRand())));
            emit(encI(opSw, 5'd0, rv, off));
            // reload either this word or the one stored by the previous round
            emit(encI(opLw, 5'd0, rl, pick(2) == 0 ? off : offPrev));
            emit(encR(fnAddu, rl, rv, rc));
            emit(encI(opSw, 5'd0, rc, pickOffset()));
            offPrev = off;
        end
    endtask

    task automatic buildBranch();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rd;
        logic [15:0] v;
        int skip;
        for (int i = 0; i < 24; i++) begin
            ra = 5'd1 + pickReg(7);
            rb = 5'd1 + pickReg(7);
            rd = 5'd1 + pickReg(7);
            v = 16'(nextRand());
            skip = 1 + int'(pick(3));
            emit(encI(opOri, 5'd0, ra, v));
            // equal or off by one so that both outcomes occur
            emit(encI(opOri, 5'd0, rb, v ^ 16'(pick(2))));
            if (pick(2) == 0) begin
                // route rb through memory so the branch waits on a load
                emit(encI(opSw, 5'd0, rb, 16'(i * 4)));
                emit(encI(opLw, 5'd0, rb, 16'(i * 4)));
            end
            emit(encI(pick(2) == 0 ? opBeq : opBne, rb, ra, 16'(skip + 1)));
            emit(encI(opAddiu, rd, rd, 16'(nextRand())));
            for (int j = 0; j < skip; j++) begin
                emit(randomAlu(8));
            end
        end
    endtask

    task automatic buildMixed();
        int len;
        int off;
        int unsigned kind;
        logic slot;
        logic [4:0] rs;
        logic [4:0] base;
        len = 320;
        slot = 1'b0;
        for (int i = 0; i < len; i++) begin
            kind = pick(10);
            rs = pickReg(8);
            base = (pick(2) == 0) ? 5'd0 : pickReg(8);
            if (kind < 2 && !slot && i <= len - 2) begin
                // forward only, and never past the closing self-branch
                off = 1 + int'(pick(4));
                if (off > len - 1 - i) begin
                    off = len - 1 - i;
                end
                emit(encI(pick(2) == 0 ? opBeq : opBne, rs,
                          pick(3) == 0 ? rs : pickReg(8), 16'(off)));
                slot = 1'b1;
            end else begin
                slot = 1'b0;
                if (kind < 4) begin
                    emit(encI(opLw, base, rs, pickOffset()));
                end else if (kind < 6) begin
                    emit(encI(opSw, base, rs, pickOffset()));
                end else begin
                    emit(randomAlu(8));
                end
            end
        end
    endtask

    initial begin
        arstN <= 1'b0;
        running = 1'b0;
        rngState = 32'h3696_33df;
        passCount = 0;
        failCount = 0;
        progLen = 0;
        endIdx = 0;
        testErrors = 0;
        testName = "";
        for (int i = 0; i < 1024; i++) begin
            prog[i] = '0;
        end

        startTest("alu");
        buildAlu();
        runTest();
        startTest("forward");
        buildForward();
        runTest();
        startTest("memory");
        buildMemory();
        runTest();
        startTest("branch");
        buildBranch();
        runTest();
        startTest("mixed");
        buildMixed();
        runTest();

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: mipsCore.f
src/mipsPkg.sv
src/pipeReg.sv
src/hazardUnit.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsCore.sv
bench/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f mipsCore.f --top-module mipsCoreTb \
    -o mipsCoreSim || exit 1
out=$(./obj_dir/mipsCoreSim)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
